// ==== rtl/hdmi_cfg_pkg.sv ====
//====================================================================
// HDMI transmitter configuration package
// bus constants, register table size and the register-write record
// shared by the table sequencer and the two-wire frame transmitter
//====================================================================

package hdmi_cfg_pkg;

   // 7-bit device address of the HDMI transmitter
   localparam logic [6:0] iic_dev_addr = 7'h39;

   // r/w bit value for a write transfer
   localparam logic iic_wr_bit = 1'b0;

   // acknowledge slots are released high by the master
   localparam logic iic_ack_rel = 1'b1;

   // clocked bit slots per frame
   // 8 address/rw, 3 ack, 16 register address and data
   localparam int iic_bit_slots = 27;

   // number of register writes in the configuration table
   localparam int cfg_entries = 58;

   localparam int cfg_index_w = $clog2(cfg_entries);

   // table index, wide enough for cfg_entries
   typedef logic [cfg_index_w-1:0] cfg_index_t;

   // one register write, address in the upper byte
   typedef struct packed {
      logic [7:0] addr;
      logic [7:0] data;
   } reg_write_t;

endpackage

// ==== rtl/iic_write_if.sv ====
//====================================================================
// register write channel
// carries one register write from the table sequencer to the
// two-wire frame transmitter with start/busy/done strobes
//====================================================================

`timescale 1ns/1ns

interface iic_write_if import hdmi_cfg_pkg::*; ();

   logic       start;   // one-cycle launch pulse
   reg_write_t wr;      // held from start until done
   logic       busy;    // frame in progress
   logic       done;    // one-cycle pulse as busy falls

   // sequencer side
   modport seq (output start, output wr, input busy, input done);

   // transmitter side
   modport tx (input start, input wr, output busy, output done);

endinterface

// ==== rtl/cfg_rom.sv ====
//====================================================================
// HDMI transmitter register table
// registered lookup of the register address and data pairs written
// after reset, power-up and format setup first, then housekeeping
//====================================================================

`timescale 1ns/1ns

module cfg_rom import hdmi_cfg_pkg::*; (
   input  logic       clk,
   input  cfg_index_t index,
   output reg_write_t entry
);

   localparam reg_write_t rom_table [cfg_entries] = '{
      {8'h41, 8'h10},   // power up
      {8'h0B, 8'hC7},   // spdif config
      {8'h14, 8'h02},   // 16-bit audio samples
      {8'h15, 8'h00},   // 24-bit rgb 4:4:4 input
      {8'h16, 8'h32},   // 8-bit color, rising edge
      {8'h17, 8'h60},   // sync polarity low
      {8'h3C, 8'h02},   // vic sent to sink
      {8'h0A, 8'h10},   // spdif audio, mclk
      {8'h55, 8'h00},   // rgb output
      {8'h73, 8'h01},   // 2-channel audio
      {8'h9D, 8'h60},   // pixel clock not divided
      {8'hAF, 8'h06},   // hdcp off, hdmi mode
      {8'hF9, 8'h00},   // fixed i2c address
      // housekeeping writes required by the chip
      {8'h3B, 8'hE0},
      {8'h44, 8'h00},
      {8'h48, 8'h00},
      {8'h94, 8'hC0},
      {8'h96, 8'h00},
      {8'h98, 8'h03},
      {8'h99, 8'h02},
      {8'h9A, 8'hE0},
      {8'h9B, 8'h18},
      {8'h9C, 8'h30},
      {8'h9F, 8'h00},
      {8'hA1, 8'h00},
      {8'hA2, 8'hA4},
      {8'hA3, 8'hA4},
      {8'hA4, 8'h08},
      {8'hA5, 8'h04},
      {8'hA6, 8'h00},
      {8'hA7, 8'h00},
      {8'hA8, 8'h00},
      {8'hA9, 8'h00},
      {8'hAA, 8'h00},
      {8'hAB, 8'h40},
      {8'hB9, 8'h00},
      {8'hBA, 8'h10},
      {8'hBB, 8'h00},
      {8'hC7, 8'h00},
      {8'hCD, 8'h00},
      {8'hCE, 8'h01},
      {8'hCF, 8'h04},
      {8'hD0, 8'h3C},
      {8'hD1, 8'hFF},
      {8'hD2, 8'h80},
      {8'hD3, 8'h80},
      {8'hD4, 8'h80},
      {8'hD5, 8'h00},
      {8'hD6, 8'h00},
      {8'hDC, 8'h00},
      {8'hDD, 8'h00},
      {8'hDE, 8'h10},
      {8'hDF, 8'h01},
      {8'hE0, 8'h3C},
      {8'hE2, 8'h00},
      {8'hE3, 8'h00},
      {8'hE4, 8'h60},
      {8'hFA, 8'h00}
   };

   // one-cycle read latency, unused indices read as zero
   always_ff @(posedge clk) begin
      if (index < cfg_index_t'(cfg_entries))
         entry <= rom_table[index];
      else
         entry <= '0;
   end

endmodule

// ==== rtl/iic_frame_tx.sv ====
//====================================================================
// two-wire write frame transmitter
// sends start, device address with write bit, register address and
// data with released ack slots, then stop, at fixed half periods
//====================================================================

`timescale 1ns/1ns

module iic_frame_tx import hdmi_cfg_pkg::*; #(
   parameter int half_period = 3000   // clk cycles per scl half period
) (
   input  logic      clk,
   input  logic      rst,
   iic_write_if.tx   bus,
   output logic      scl,
   output logic      sda
);

   localparam int cnt_w  = (half_period > 1) ? $clog2(half_period) : 1;
   localparam int slot_w = $clog2(iic_bit_slots);

   typedef enum logic [2:0] {
      ph_ready,
      ph_start,       // sda low, scl high
      ph_low,         // scl low, sda set up
      ph_high,        // scl high, data sampled by the slave
      ph_stop_low,
      ph_stop_high,
      ph_idle         // bus released before done
   } phase_t;

   phase_t                   phase;
   logic [cnt_w-1:0]         half_cnt;
   logic [slot_w-1:0]        slot;
   logic [iic_bit_slots-1:0] shreg;
   logic                     half_end;
   logic                     launch;
   logic                     last_slot;
   logic                     shift_out;

   assign half_end  = (half_cnt == cnt_w'(half_period - 1));
   assign launch    = (phase == ph_ready) && bus.start;
   assign last_slot = (slot == slot_w'(iic_bit_slots - 1));

   // next bit goes onto sda at the start of every low half
   assign shift_out = half_end &&
                      ((phase == ph_start) || (phase == ph_high && !last_slot));

   // half-period pacing
   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         half_cnt <= '0;
      else if (phase == ph_ready || half_end)
         half_cnt <= '0;
      else
         half_cnt <= half_cnt + cnt_w'(1);
   end

   always_ff @(posedge clk) begin
      if (launch)
         shreg <= {iic_dev_addr, iic_wr_bit, iic_ack_rel, bus.wr.addr,
                   iic_ack_rel, bus.wr.data, iic_ack_rel};
      else if (shift_out)
         shreg <= {shreg[iic_bit_slots-2:0], 1'b1};
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         phase    <= ph_ready;
         slot     <= '0;
         scl      <= 1'b1;
         sda      <= 1'b1;
         bus.busy <= 1'b0;
         bus.done <= 1'b0;
      end else begin
         bus.done <= 1'b0;   // pulse only
         case (phase)
            ph_ready: begin
               if (bus.start) begin
                  phase    <= ph_start;
                  sda      <= 1'b0;   // start condition, scl stays high
                  bus.busy <= 1'b1;
               end
            end
            ph_start: begin
               if (half_end) begin
                  phase <= ph_low;
                  slot  <= '0;
                  scl   <= 1'b0;
                  sda   <= shreg[iic_bit_slots-1];
               end
            end
            ph_low: begin
               if (half_end) begin
                  phase <= ph_high;
                  scl   <= 1'b1;
               end
            end
            ph_high: begin
               if (half_end) begin
                  scl <= 1'b0;
                  if (last_slot) begin
                     phase <= ph_stop_low;
                     sda   <= 1'b0;   // hold low so the stop edge is a rise
                  end else begin
                     phase <= ph_low;
                     slot  <= slot + slot_w'(1);
                     sda   <= shreg[iic_bit_slots-1];
                  end
               end
            end
            ph_stop_low: begin
               if (half_end) begin
                  phase <= ph_stop_high;
                  scl   <= 1'b1;
               end
            end
            ph_stop_high: begin
               if (half_end) begin
                  phase <= ph_idle;
                  sda   <= 1'b1;   // stop condition
               end
            end
            ph_idle: begin
               if (half_end) begin
                  phase    <= ph_ready;
                  bus.busy <= 1'b0;
                  bus.done <= 1'b1;
               end
            end
            default: begin
               phase <= ph_ready;
               scl   <= 1'b1;
               sda   <= 1'b1;
            end
         endcase
      end
   end

endmodule

// ==== rtl/cfg_sequencer.sv ====
//====================================================================
// register table sequencer
// walks the configuration table after reset, launches one bus frame
// per entry and holds done high once the last write has gone out
//====================================================================

`timescale 1ns/1ns

module cfg_sequencer import hdmi_cfg_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   iic_write_if.seq  bus,
   output logic      done
);

   typedef enum logic [1:0] {
      st_fetch,      // table read in flight
      st_launch,
      st_wait,       // frame on the bus
      st_finished
   } state_t;

   state_t     state;
   cfg_index_t index;
   reg_write_t entry;

   cfg_rom u_rom (
      .clk   (clk),
      .index (index),
      .entry (entry)
   );

   // rom output holds while index is unchanged, so wr stays stable
   assign bus.wr    = entry;
   assign bus.start = (state == st_launch) && !bus.busy;
   assign done      = (state == st_finished);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= st_fetch;
         index <= '0;
      end else begin
         case (state)
            st_fetch:  state <= st_launch;
            st_launch: begin
               if (!bus.busy)
                  state <= st_wait;
            end
            st_wait: begin
               if (bus.done) begin
                  if (index == cfg_index_t'(cfg_entries - 1)) begin
                     state <= st_finished;
                  end else begin
                     index <= index + cfg_index_t'(1);
                     state <= st_fetch;
                  end
               end
            end
            st_finished: state <= st_finished;   // until next reset
            default:     state <= st_fetch;
         endcase
      end
   end

endmodule

// ==== rtl/hdmi_iic_config.sv ====
//====================================================================
// HDMI transmitter configuration top level
// programs the transmitter register map over a write-only two-wire
// bus after reset, then raises done
//====================================================================

`timescale 1ns/1ns

module hdmi_iic_config #(
   parameter int half_period = 3000   // 200 MHz clk, 30 us scl period
) (
   input  logic clk,
   input  logic rst,
   output logic scl,
   output logic sda,
   output logic done
);

   // sequencer to transmitter write channel
   iic_write_if bus ();

   cfg_sequencer u_seq (
      .clk  (clk),
      .rst  (rst),
      .bus  (bus),
      .done (done)
   );

   iic_frame_tx #(
      .half_period (half_period)
   ) u_tx (
      .clk (clk),
      .rst (rst),
      .bus (bus),
      .scl (scl),
      .sda (sda)
   );

endmodule

// ==== verif/iic_config_assert.sv ====
//====================================================================
// HDMI configuration bus assertions
// idle levels in reset and after done, sda edges against scl and
// the number of scl pulses in each complete frame
//====================================================================

`timescale 1ns/1ns

module iic_config_assert import hdmi_cfg_pkg::*; (
   input logic clk,
   input logic rst,
   input logic scl,
   input logic sda,
   input logic done
);

   logic scl_q     = 1'b1;
   logic sda_q     = 1'b1;
   int   scl_rises = 0;   // counted from the last start
   int   fail_cnt  = 0;   // failed assertions

   always @(posedge clk) begin
      scl_q <= scl;
      sda_q <= sda;
      if (scl && scl_q && sda_q && !sda)
         scl_rises <= 0;
      else if (scl && !scl_q)
         scl_rises <= scl_rises + 1;
   end

   // with scl high, only start and stop move sda
   sda_not_on_scl_rise: assert property (@(posedge clk) disable iff (rst)
      $changed(sda) |-> !scl || $past(scl))
      else begin
         fail_cnt++;
         $error("sda changed as scl rose");
      end

   // 27 bit slots plus the stop clock
   stop_after_full_frame: assert property (@(posedge clk) disable iff (rst)
      (scl && $past(scl) && $rose(sda)) |-> scl_rises == iic_bit_slots + 1)
      else begin
         fail_cnt++;
         $error("stop condition after %0d scl pulses", scl_rises);
      end

   reset_levels: assert property (@(posedge clk)
      rst && $past(rst) |-> scl && sda && !done)
      else begin
         fail_cnt++;
         $error("bus not idle in reset");
      end

   done_bus_idle: assert property (@(posedge clk)
      done |-> scl && sda)
      else begin
         fail_cnt++;
         $error("bus active while done is high");
      end

   done_holds: assert property (@(posedge clk) disable iff (rst)
      done |=> done)
      else begin
         fail_cnt++;
         $error("done fell without reset");
      end

endmodule

bind hdmi_iic_config iic_config_assert u_assert (
   .clk  (clk),
   .rst  (rst),
   .scl  (scl),
   .sda  (sda),
   .done (done)
);

// ==== verif/iic_monitor.sv ====
//====================================================================
// two-wire bus monitor
// decodes write frames from scl and sda, compares each one with the
// expected register table and checks reset and done behavior
//====================================================================

`timescale 1ns/1ns

module iic_monitor import hdmi_cfg_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        scl,
   input  logic        sda,
   input  logic        done,
   input  logic [15:0] exp_tab [cfg_entries],
   output int          errors,
   output int          run_frames,   // frames since the last reset
   output int          total_frames
);

   logic                   scl_q     = 1'b1;
   logic                   sda_q     = 1'b1;
   logic                   done_q    = 1'b0;
   logic                   rst_q     = 1'b0;
   logic                   in_frame  = 1'b0;
   logic [iic_bit_slots:0] bits      = '0;   // bit slots plus the stop clock
   int                     nbits     = 0;
   int                     err_cnt   = 0;
   int                     run_cnt   = 0;
   int                     total_cnt = 0;

   assign errors       = err_cnt;
   assign run_frames   = run_cnt;
   assign total_frames = total_cnt;

   task automatic report_error(input string msg);
      err_cnt++;
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
   endtask

   task automatic check_frame();
      logic [15:0] want;
      want = exp_tab[cfg_index_t'(run_cnt)];
      if (nbits != iic_bit_slots + 1) begin
         report_error($sformatf("frame %0d has %0d scl pulses", run_cnt, nbits));
      end else begin
         if (bits[27:20] != {iic_dev_addr, 1'b0})
            report_error($sformatf("frame %0d address byte %02h", run_cnt, bits[27:20]));
         if (bits[19] !== 1'b1 || bits[10] !== 1'b1 || bits[1] !== 1'b1)
            report_error($sformatf("frame %0d ack slot driven low", run_cnt));
         if (bits[18:11] != want[15:8])
            report_error($sformatf("frame %0d register %02h, expected %02h",
                                   run_cnt, bits[18:11], want[15:8]));
         if (bits[9:2] != want[7:0])
            report_error($sformatf("frame %0d data %02h, expected %02h",
                                   run_cnt, bits[9:2], want[7:0]));
      end
   endtask

   always @(posedge clk) begin
      if (rst) begin
         if (rst_q && (scl !== 1'b1 || sda !== 1'b1 || done !== 1'b0))
            report_error("scl, sda or done not at reset level");
         in_frame <= 1'b0;   // cut frame is dropped
         run_cnt  <= 0;
      end else begin
         if (done_q && !done)
            report_error("done fell without reset");
         if (done && !done_q && run_cnt != cfg_entries)
            report_error($sformatf("done rose after %0d frames", run_cnt));
         if (done && (scl !== 1'b1 || sda !== 1'b1))
            report_error("bus activity while done is high");
         if (scl && scl_q && sda_q && !sda) begin   // start
            if (run_cnt >= cfg_entries)
               report_error("frame started after the last table entry");
            in_frame <= 1'b1;
            nbits    <= 0;
         end else if (scl && scl_q && !sda_q && sda && in_frame) begin   // stop
            if (run_cnt < cfg_entries)
               check_frame();
            in_frame  <= 1'b0;
            run_cnt   <= run_cnt + 1;
            total_cnt <= total_cnt + 1;
         end else if (scl && !scl_q && in_frame) begin
            bits  <= {bits[iic_bit_slots-1:0], sda};
            nbits <= nbits + 1;
         end
      end
      scl_q  <= scl;
      sda_q  <= sda;
      done_q <= done;
      rst_q  <= rst;
   end

endmodule

// ==== verif/tb_hdmi_iic_config.sv ====
//====================================================================
// HDMI configuration testbench
// runs full and reset-cut configuration sequences on the DUT while
// the bus monitor decodes and compares every frame
//====================================================================

`timescale 1ns/1ns

module tb_hdmi_iic_config import hdmi_cfg_pkg::*; ();

   localparam int half_period  = 4;
   localparam int frame_cycles = (2 * iic_bit_slots + 4) * half_period;
   localparam int timeout_cycles = 3 * cfg_entries * frame_cycles + 5000;
   localparam int idle_hold    = 300;   // quiet cycles watched after done
   localparam int n_phases     = 4;

   typedef struct packed {
      int rst_len;   // reset cycles
      int frames;    // complete frames before the next reset
   } phase_t;

   // run phases, cfg_entries means run to done
   phase_t phases [n_phases] = '{'{16, 0}, '{16, cfg_entries}, '{5, 3}, '{16, cfg_entries}};

   // register address and data, in table order
   logic [15:0] exp_tab [cfg_entries] = '{
      16'h4110, 16'h0BC7, 16'h1402, 16'h1500, 16'h1632, 16'h1760, 16'h3C02, 16'h0A10,
      16'h5500, 16'h7301, 16'h9D60, 16'hAF06, 16'hF900, 16'h3BE0, 16'h4400, 16'h4800,
      16'h94C0, 16'h9600, 16'h9803, 16'h9902, 16'h9AE0, 16'h9B18, 16'h9C30, 16'h9F00,
      16'hA100, 16'hA2A4, 16'hA3A4, 16'hA408, 16'hA504, 16'hA600, 16'hA700, 16'hA800,
      16'hA900, 16'hAA00, 16'hAB40, 16'hB900, 16'hBA10, 16'hBB00, 16'hC700, 16'hCD00,
      16'hCE01, 16'hCF04, 16'hD03C, 16'hD1FF, 16'hD280, 16'hD380, 16'hD480, 16'hD500,
      16'hD600, 16'hDC00, 16'hDD00, 16'hDE10, 16'hDF01, 16'hE03C, 16'hE200, 16'hE300,
      16'hE460, 16'hFA00
   };

   logic        clk;
   logic        rst;
   logic        scl;
   logic        sda;
   logic        done;
   int          errors;
   int          run_frames;
   int          total_frames;
   int          cycles = 0;
   int          expected_frames = 0;
   int          tb_errors = 0;
   logic [31:0] rnd;

   hdmi_iic_config #(
      .half_period (half_period)
   ) uut (
      .clk  (clk),
      .rst  (rst),
      .scl  (scl),
      .sda  (sda),
      .done (done)
   );

   iic_monitor mon (
      .clk          (clk),
      .rst          (rst),
      .scl          (scl),
      .sda          (sda),
      .done         (done),
      .exp_tab      (exp_tab),
      .errors       (errors),
      .run_frames   (run_frames),
      .total_frames (total_frames)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("timeout: run not finished after %0d clock cycles", timeout_cycles);
         $display("** FAIL **");
         $finish;
      end
   end

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      rnd = 32'd46;
      for (int p = 0; p < n_phases; p++) begin
         rst = 1'b1;
         repeat (phases[p].rst_len) @(negedge clk);
         rst = 1'b0;
         expected_frames += phases[p].frames;
         if (phases[p].frames >= cfg_entries) begin
            while (done !== 1'b1) @(negedge clk);
            repeat (idle_hold) @(negedge clk);   // bus must stay quiet
         end else begin
            while (run_frames < phases[p].frames) @(negedge clk);
            while (sda !== 1'b0) @(negedge clk);   // next frame under way
            rnd = xorshift(rnd);
            repeat (1 + rnd % (frame_cycles - 8)) @(negedge clk);
         end
      end
      if (total_frames != expected_frames) begin
         $display("CHECK FAILED at %0t ns: %0d frames decoded, %0d expected",
                  $time, total_frames, expected_frames);
         tb_errors++;
      end
      $display("frames %0d, monitor errors %0d, testbench errors %0d, assertion failures %0d",
               total_frames, errors, tb_errors, uut.u_assert.fail_cnt);
      if (errors == 0 && tb_errors == 0 && uut.u_assert.fail_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
rtl/hdmi_cfg_pkg.sv
rtl/iic_write_if.sv
rtl/cfg_rom.sv
rtl/iic_frame_tx.sv
rtl/cfg_sequencer.sv
rtl/hdmi_iic_config.sv
verif/iic_config_assert.sv
verif/iic_monitor.sv
verif/tb_hdmi_iic_config.sv

// ==== Makefile ====
# Verilator build and run of the HDMI configuration testbench

SIM  := obj_dir/Vtb_hdmi_iic_config
SRCS := $(filter-out +%,$(shell cat verilog.f))

.PHONY: all run clean

all: run

$(SIM): verilog.f $(SRCS)
	verilator --binary --assert --top-module tb_hdmi_iic_config -f verilog.f -o Vtb_hdmi_iic_config

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q -F '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log
